// ==== run.sh ====
#!/bin/bash
# build and run the usb_periph testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
   --top-module tb_usb_periph -f usb_periph.f -o sim_usb_periph
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/sim_usb_periph)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -qxF "TEST RESULT: PASS"; then
   exit 0
fi
exit 1

// ==== tb_usb_periph.sv ====
`timescale 1ns/1ns

module tb_usb_periph;
   import usb_pkg::*;

   localparam int RX_DEPTH = 4;
   localparam int N_MODE   = 30;
   localparam int N_SER_TX = 50;
   localparam int N_BURST  = 20;
   localparam int N_KBD    = 60;
   // generous cycle budget per step of each test
   localparam int TOTAL_CYCLES = 200 + N_MODE * 6 + N_SER_TX * 6 + N_BURST * 100 + N_KBD * 10;

   logic        clk_i;
   logic        rst_i;
   logic        write_i;
   logic [3:0]  data_be_i;
   logic [3:0]  addr_i;
   logic [31:0] wdata_i;
   logic [31:0] rdata_o;
   logic        host_rx_valid_i;
   logic [7:0]  host_rx_data_i;
   logic        host_tx_valid_o;
   logic [7:0]  host_tx_data_o;
   logic        dp_pull_o;

   logic [1:0]  m_ccr;
   logic [7:0]  rxq[$];     // RDR at the front, FIFO behind it
   logic        m_ovf;
   logic        m_kbd_vld;  // a report was sent since the keyboard left reset
   logic [7:0]  m_kbd_mod;
   logic [7:0]  m_kbd_key;
   tdr_word_t   m_tdr;

   usb_periph #(.RX_DEPTH(RX_DEPTH)) u_dut (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .write_i         (write_i),
      .data_be_i       (data_be_i),
      .addr_i          (addr_i),
      .wdata_i         (wdata_i),
      .rdata_o         (rdata_o),
      .host_rx_valid_i (host_rx_valid_i),
      .host_rx_data_i  (host_rx_data_i),
      .host_tx_valid_o (host_tx_valid_o),
      .host_tx_data_o  (host_tx_data_o),
      .dp_pull_o       (dp_pull_o)
   );

   initial begin
      clk_i = 1'b0;
      forever #5 clk_i = ~clk_i;
   end

   initial begin
      #(TOTAL_CYCLES * 20);
      $display("watchdog expired, the tests did not finish in time");
      $display("TEST RESULT: FAIL");
      $fatal(1, "timeout");
   end

   task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         $display("ERR %s: expected %h, actual %h", name, exp, act);
         $display("TEST RESULT: FAIL");
         $fatal(1, "mismatch in %s", name);
      end
   endtask

   function automatic logic connected();
      return (m_ccr == MODE_SERIAL) || (m_ccr == MODE_KEYBOARD);
   endfunction

   function automatic logic [31:0] sta_exp(input logic busy);
      logic [31:0] s;
      s                 = '0;
      s[STA_CONNECTED]  = connected();
      s[STA_RECV_VALID] = (rxq.size() > 0);
      s[STA_BUSY]       = busy;
      s[STA_OVERFLOW]   = m_ovf;
      return s;
   endfunction

   // read path is combinational, so no clock edge needed
   task automatic check_reg(input string name, input logic [3:0] addr, input logic [31:0] exp);
      addr_i = addr;
      #1;
      check(name, exp, rdata_o);
   endtask

   task automatic reg_write(input logic [3:0] addr, input logic [31:0] data, input logic [3:0] be);
      @(negedge clk_i);
      write_i   = 1'b1;
      addr_i    = addr;
      wdata_i   = data;
      data_be_i = be;
      @(negedge clk_i);
      write_i   = 1'b0; // returns in the cycle after the write edge
   endtask

   task automatic ccr_write(input logic [31:0] data, input logic [3:0] be);
      logic [1:0] c;
      c = be[0] ? data[1:0] : m_ccr;
      reg_write(USB_CCR, data, be);
      if (m_ccr == MODE_SERIAL && c != MODE_SERIAL) begin
         while (rxq.size() > 1)
            void'(rxq.pop_back()); // serial FIFO flushed, RDR stays
      end
      if (c != MODE_KEYBOARD)
         m_kbd_vld = 1'b0;
      m_ccr = c;
      check("dp_pull", 32'(connected()), 32'(dp_pull_o));
      check_reg("ccr readback", USB_CCR, {30'b0, m_ccr});
      check_reg("sta after ccr", USB_STA, sta_exp(1'b0));
   endtask

   task automatic tdr_write(input logic [31:0] data, input logic [3:0] be);
      for (int i = 0; i < 4; i++) begin
         if (be[i])
            m_tdr.raw[8*i +: 8] = data[8*i +: 8];
      end
      reg_write(USB_TDR, data, be);
   endtask

   task automatic host_byte(input logic [7:0] b);
      @(negedge clk_i);
      host_rx_valid_i = 1'b1;
      host_rx_data_i  = b;
      @(negedge clk_i);
      host_rx_valid_i = 1'b0;
      @(negedge clk_i); // byte has had its edge to reach RDR
      if (m_ccr == MODE_SERIAL) begin
         if (rxq.size() < RX_DEPTH + 1)
            rxq.push_back(b);
         else
            m_ovf = 1'b1;
      end else if (m_ccr == MODE_KEYBOARD && rxq.size() == 0) begin
         rxq.push_back(b); // LED byte, dropped when RDR is taken
      end
   endtask

   task automatic take_rdr();
      check_reg("recv_valid set", USB_STA, sta_exp(1'b0));
      check_reg("rdr data", USB_RDR, {24'b0, rxq[0]});
      reg_write(USB_STA, 32'h1 << STA_RECV_VALID, 4'h1);
      void'(rxq.pop_front());
      @(negedge clk_i); // next FIFO byte moves up
      check_reg("sta after clear", USB_STA, sta_exp(1'b0));
   endtask

   task automatic clear_ovf();
      reg_write(USB_STA, 32'h1 << STA_OVERFLOW, 4'h1);
      m_ovf = 1'b0;
      check_reg("overflow cleared", USB_STA, sta_exp(1'b0));
   endtask

   task automatic send_report(input logic [7:0] mod, input logic [7:0] key);
      logic changed;
      changed = !m_kbd_vld || (mod != m_kbd_mod) || (key != m_kbd_key);
      tdr_write({16'($urandom), mod, key}, 4'hF);
      if (changed) begin
         check("report modifier", {23'b0, 1'b1, mod}, {23'b0, host_tx_valid_o, host_tx_data_o});
         check_reg("busy on modifier", USB_STA, sta_exp(1'b1));
         @(negedge clk_i);
         check("report keycode", {23'b0, 1'b1, key}, {23'b0, host_tx_valid_o, host_tx_data_o});
         check_reg("busy on keycode", USB_STA, sta_exp(1'b1));
         m_kbd_vld = 1'b1;
         m_kbd_mod = mod;
         m_kbd_key = key;
      end else begin
         check("repeat report silent", 32'h0, 32'(host_tx_valid_o));
      end
      @(negedge clk_i);
      check("report done", 32'h0, 32'(host_tx_valid_o));
      check_reg("busy cleared", USB_STA, sta_exp(1'b0));
   endtask

   initial begin
      logic [3:0] be;
      logic [7:0] mod;
      logic [7:0] key;
      int         n;

      void'($urandom(32'h5f42_7d22));
      rst_i           = 1'b1;
      write_i         = 1'b0;
      data_be_i       = 4'h0;
      addr_i          = 4'h0;
      wdata_i         = 32'h0;
      host_rx_valid_i = 1'b0;
      host_rx_data_i  = 8'h00;
      m_ccr           = MODE_IDLE;
      m_ovf           = 1'b0;
      m_kbd_vld       = 1'b0;
      m_kbd_mod       = 8'h00;
      m_kbd_key       = 8'h00;
      m_tdr           = '0;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;

      // reset state, idle ignores the host
      check_reg("ccr after reset", USB_CCR, 32'h0);
      check_reg("rdr after reset", USB_RDR, 32'h0);
      check_reg("sta after reset", USB_STA, 32'h0);
      check("dp_pull after reset", 32'h0, 32'(dp_pull_o));
      check("tx_valid after reset", 32'h0, 32'(host_tx_valid_o));
      for (int i = 0; i < 8; i++)
         host_byte(8'($urandom));
      check_reg("sta idle rx", USB_STA, 32'h0);
      check_reg("rdr idle rx", USB_RDR, 32'h0);

      for (int i = 0; i < N_MODE; i++)
         ccr_write($urandom, 4'($urandom_range(0, 15)));

      // serial transmit, first write defines the whole TDR
      ccr_write(32'(MODE_SERIAL), 4'h1);
      for (int i = 0; i < N_SER_TX; i++) begin
         be = (i == 0) ? 4'hF : 4'($urandom_range(0, 15));
         tdr_write($urandom, be);
         check("serial tx pulse", {23'b0, 1'b1, m_tdr.ser.data_byte},
               {23'b0, host_tx_valid_o, host_tx_data_o});
         @(negedge clk_i);
         check("serial tx single", 32'h0, 32'(host_tx_valid_o));
      end

      // serial receive bursts with partial drains
      for (int k = 0; k < N_BURST; k++) begin
         n = $urandom_range(1, 8);
         for (int j = 0; j < n; j++) begin
            host_byte(8'($urandom));
            if ($urandom_range(0, 1) == 1)
               @(negedge clk_i);
         end
         check_reg("sta after burst", USB_STA, sta_exp(1'b0));
         if (m_ovf)
            clear_ovf();
         n = $urandom_range(0, rxq.size());
         for (int j = 0; j < n; j++)
            take_rdr();
      end
      while (rxq.size() > 0)
         take_rdr();

      // keyboard reports from a small set so repeats happen
      ccr_write(32'(MODE_KEYBOARD), 4'h1);
      for (int k = 0; k < N_KBD; k++) begin
         if ($urandom_range(0, 3) != 0) begin
            send_report(8'($urandom_range(0, 1)), 8'($urandom_range(4, 5)));
         end else begin
            host_byte(8'($urandom));
            if (rxq.size() > 0 && $urandom_range(0, 1) == 1)
               take_rdr();
         end
      end
      while (rxq.size() > 0)
         take_rdr();

      // leave serial with bytes queued, then come back
      mod = m_kbd_mod;
      key = m_kbd_key;
      ccr_write(32'(MODE_SERIAL), 4'h1);
      for (int j = 0; j < 3; j++)
         host_byte(8'($urandom));
      ccr_write(32'(MODE_KEYBOARD), 4'h1);
      ccr_write(32'(MODE_SERIAL), 4'h1);
      take_rdr(); // RDR kept its byte, FIFO behind it is gone
      ccr_write(32'(MODE_KEYBOARD), 4'h1);
      send_report(mod, key); // same as the last one, still sent after reset

      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// ==== usb_func_sel.sv ====
`timescale 1ns/1ns

module usb_func_sel #(
   parameter int RX_DEPTH = 4
) (
   input  logic       clk_i,
   input  logic       rst_i,
   usb_ctrl_if.sel    ctrl,
   input  logic       host_rx_valid_i,
   input  logic [7:0] host_rx_data_i,
   output logic       host_tx_valid_o,
   output logic [7:0] host_tx_data_o,
   output logic       dp_pull_o,
   usb_fn_if.sel      ser,
   usb_fn_if.sel      kbd
);
   import usb_pkg::*;

   localparam int FW = $clog2(RX_DEPTH + 1);

   logic [1:0]    mode_q;
   logic [1:0]    fn_en;          // {keyboard, serial}
   logic          ovf_mux;
   logic          ovf_replay_q;
   logic          ser_acc;
   logic [FW-1:0] ser_fill_q;     // serial backlog as seen from here

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         mode_q       <= MODE_IDLE;
         ovf_replay_q <= 1'b0;
      end else begin
         mode_q       <= ctrl.mode;
         ovf_replay_q <= ovf_mux && ctrl.flush_ovf; // don't lose it on the clear edge
      end
   end

   assign fn_en[0] = (mode_q == MODE_SERIAL);
   assign fn_en[1] = (mode_q == MODE_KEYBOARD);

   assign ser.fn_rst = !fn_en[0];
   assign kbd.fn_rst = !fn_en[1];

   // only the owner sees host bytes and strobes
   assign ser.host_rx_valid = host_rx_valid_i && fn_en[0];
   assign kbd.host_rx_valid = host_rx_valid_i && fn_en[1];
   assign ser.host_rx_data  = host_rx_data_i;
   assign kbd.host_rx_data  = host_rx_data_i;
   assign ser.send_strobe   = ctrl.send_strobe && fn_en[0];
   assign kbd.send_strobe   = ctrl.send_strobe && fn_en[1];
   assign ser.send_word     = ctrl.send_word;
   assign kbd.send_word     = ctrl.send_word;
   assign ser.up_take       = fn_en[0] && ctrl.up_valid && ctrl.rdr_free;
   assign kbd.up_take       = fn_en[1] && ctrl.up_valid && ctrl.rdr_free;

   always_comb begin
      host_tx_valid_o = 1'b0;
      host_tx_data_o  = 8'h00;
      ctrl.up_valid   = 1'b0;
      ctrl.up_data    = 8'h00;
      ctrl.busy       = 1'b0;
      ovf_mux         = 1'b0;
      if (fn_en[0]) begin
         host_tx_valid_o = ser.host_tx_valid;
         host_tx_data_o  = ser.host_tx_data;
         ctrl.up_valid   = ser.up_valid;
         ctrl.up_data    = ser.up_data;
         ctrl.busy       = ser.busy;
         ovf_mux         = ser.overflow;
      end else if (fn_en[1]) begin
         host_tx_valid_o = kbd.host_tx_valid;
         host_tx_data_o  = kbd.host_tx_data;
         ctrl.up_valid   = kbd.up_valid;
         ctrl.up_data    = kbd.up_data;
         ctrl.busy       = kbd.busy;
         ovf_mux         = kbd.overflow;
      end
   end

   assign ctrl.overflow  = ovf_mux || ovf_replay_q;
   assign ctrl.connected = |fn_en;
   assign dp_pull_o      = ctrl.connected;

   assign ser_acc = ser.host_rx_valid && !ser.overflow;

   always_ff @(posedge clk_i) begin
      if (rst_i || ser.fn_rst) begin
         ser_fill_q <= '0;
      end else begin
         case ({ser_acc, ser.up_take})
            2'b10:   ser_fill_q <= ser_fill_q + 1'b1;
            2'b01:   ser_fill_q <= ser_fill_q - 1'b1;
            default: ser_fill_q <= ser_fill_q;
         endcase
      end
   end

   // serial only drops when its FIFO really is full
   a_ser_ovf: assert property (@(posedge clk_i) disable iff (rst_i)
      ser.overflow |-> (ser_fill_q == FW'(RX_DEPTH)) && !ser.up_take);

endmodule

// ==== usb_if.sv ====
`timescale 1ns/1ns

// register bank <-> function selector
interface usb_ctrl_if;
   import usb_pkg::*;

   logic [1:0] mode;        // next mode, registered in the selector
   logic       send_strobe;
   tdr_word_t  send_word;
   logic       rdr_free;
   logic       flush_ovf;
   logic       up_valid;
   logic [7:0] up_data;
   logic       busy;
   logic       connected;
   logic       overflow;

   modport regs (output mode, send_strobe, send_word, rdr_free, flush_ovf,
                 input  up_valid, up_data, busy, connected, overflow);
   modport sel  (input  mode, send_strobe, send_word, rdr_free, flush_ovf,
                 output up_valid, up_data, busy, connected, overflow);
endinterface

// function selector <-> one device function
interface usb_fn_if;
   import usb_pkg::*;

   logic       fn_rst;
   logic       host_rx_valid;
   logic [7:0] host_rx_data;
   logic       send_strobe;
   tdr_word_t  send_word;
   logic       up_take;
   logic       host_tx_valid;
   logic [7:0] host_tx_data;
   logic       up_valid;
   logic [7:0] up_data;
   logic       busy;
   logic       overflow;

   modport sel (output fn_rst, host_rx_valid, host_rx_data, send_strobe, send_word, up_take,
                input  host_tx_valid, host_tx_data, up_valid, up_data, busy, overflow);
   modport fn  (input  fn_rst, host_rx_valid, host_rx_data, send_strobe, send_word, up_take,
                output host_tx_valid, host_tx_data, up_valid, up_data, busy, overflow);
endinterface

// ==== usb_keyboard_fn.sv ====
`timescale 1ns/1ns

module usb_keyboard_fn (
   input logic  clk_i,
   usb_fn_if.fn bus
);

   logic       tx_valid_q;
   logic       key_next_q;  // keycode goes out next
   logic       last_vld_q;
   logic       hold_vld_q;
   logic [7:0] tx_data_q;
   logic [7:0] last_mod_q;
   logic [7:0] last_key_q;
   logic [7:0] hold_q;
   logic       start;

   // only a changed report, or the first one, goes to the host
   assign start = bus.send_strobe && !tx_valid_q &&
                  (!last_vld_q ||
                   bus.send_word.kbd.modifier != last_mod_q ||
                   bus.send_word.kbd.keycode != last_key_q);

   always_ff @(posedge clk_i) begin
      if (bus.fn_rst) begin
         tx_valid_q <= 1'b0;
         key_next_q <= 1'b0;
         last_vld_q <= 1'b0;
         hold_vld_q <= 1'b0;
      end else begin
         hold_vld_q <= bus.host_rx_valid; // lost if RDR is not free next edge
         if (start) begin
            tx_valid_q <= 1'b1;
            key_next_q <= 1'b1;
            last_vld_q <= 1'b1;
         end else if (key_next_q) begin
            key_next_q <= 1'b0;
         end else begin
            tx_valid_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (start) begin
         last_mod_q <= bus.send_word.kbd.modifier;
         last_key_q <= bus.send_word.kbd.keycode;
         tx_data_q  <= bus.send_word.kbd.modifier;
      end else if (key_next_q) begin
         tx_data_q <= last_key_q;
      end
      if (bus.host_rx_valid)
         hold_q <= bus.host_rx_data; // LED byte
   end

   assign bus.host_tx_valid = tx_valid_q;
   assign bus.host_tx_data  = tx_data_q;
   assign bus.busy          = tx_valid_q;
   assign bus.up_valid      = hold_vld_q;
   assign bus.up_data       = hold_q;
   assign bus.overflow      = 1'b0;

endmodule

// ==== usb_periph.f ====
usb_pkg.sv
usb_if.sv
usb_regs.sv
usb_func_sel.sv
usb_serial_fn.sv
usb_keyboard_fn.sv
usb_periph.sv
tb_usb_periph.sv

// ==== usb_periph.sv ====
`timescale 1ns/1ns

module usb_periph #(
   parameter int RX_DEPTH = 4
) (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        write_i,
   input  logic [3:0]  data_be_i,
   input  logic [3:0]  addr_i,
   input  logic [31:0] wdata_i,
   output logic [31:0] rdata_o,
   input  logic        host_rx_valid_i,
   input  logic [7:0]  host_rx_data_i,
   output logic        host_tx_valid_o,
   output logic [7:0]  host_tx_data_o,
   output logic        dp_pull_o
);

   usb_ctrl_if ctrl_if ();
   usb_fn_if   ser_if ();
   usb_fn_if   kbd_if ();

   usb_regs u_regs (
      .clk_i     (clk_i),
      .rst_i     (rst_i),
      .write_i   (write_i),
      .data_be_i (data_be_i),
      .addr_i    (addr_i),
      .wdata_i   (wdata_i),
      .rdata_o   (rdata_o),
      .ctrl      (ctrl_if)
   );

   usb_func_sel #(.RX_DEPTH(RX_DEPTH)) u_sel (
      .clk_i           (clk_i),
      .rst_i           (rst_i),
      .ctrl            (ctrl_if),
      .host_rx_valid_i (host_rx_valid_i),
      .host_rx_data_i  (host_rx_data_i),
      .host_tx_valid_o (host_tx_valid_o),
      .host_tx_data_o  (host_tx_data_o),
      .dp_pull_o       (dp_pull_o),
      .ser             (ser_if),
      .kbd             (kbd_if)
   );

   usb_serial_fn #(.RX_DEPTH(RX_DEPTH)) u_serial (
      .clk_i (clk_i),
      .bus   (ser_if)
   );

   usb_keyboard_fn u_keyboard (
      .clk_i (clk_i),
      .bus   (kbd_if)
   );

endmodule

// ==== usb_pkg.sv ====
package usb_pkg;

   // register byte offsets on addr_i
   localparam logic [3:0] USB_CCR = 4'd0;
   localparam logic [3:0] USB_RDR = 4'd4;
   localparam logic [3:0] USB_TDR = 4'd8;
   localparam logic [3:0] USB_STA = 4'd12;

   // function select codes, 3 falls back to idle
   localparam logic [1:0] MODE_IDLE     = 2'd0;
   localparam logic [1:0] MODE_SERIAL   = 2'd1;
   localparam logic [1:0] MODE_KEYBOARD = 2'd2;

   // status register bits
   localparam int STA_CONNECTED  = 0;
   localparam int STA_RECV_VALID = 1; // w1c
   localparam int STA_BUSY       = 2;
   localparam int STA_OVERFLOW   = 3; // sticky, w1c

   // TDR word, read differently by each function
   typedef union packed {
      logic [31:0] raw;
      struct packed {
         logic [23:0] unused;
         logic [7:0]  data_byte;
      } ser;
      struct packed {
         logic [15:0] unused;
         logic [7:0]  modifier;
         logic [7:0]  keycode;
      } kbd;
   } tdr_word_t;

endpackage

// ==== usb_regs.sv ====
`timescale 1ns/1ns

module usb_regs (
   input  logic        clk_i,
   input  logic        rst_i,
   input  logic        write_i,
   input  logic [3:0]  data_be_i,
   input  logic [3:0]  addr_i,
   input  logic [31:0] wdata_i,
   output logic [31:0] rdata_o,
   usb_ctrl_if.regs    ctrl
);
   import usb_pkg::*;

   logic [3:0] reg_addr;
   logic       wr_ccr;
   logic       wr_tdr;
   logic       wr_sta;
   logic [1:0] ccr_q;
   logic [1:0] ccr_nxt;
   tdr_word_t  tdr_q;
   tdr_word_t  tdr_nxt;
   logic [7:0] rdr_q;
   logic       recv_valid_q;
   logic       ovf_q;
   logic       clr_recv;
   logic       rdr_load;
   logic [3:0] sta;

   assign reg_addr = {addr_i[3:2], 2'b00}; // word decode only
   assign wr_ccr   = write_i && (reg_addr == USB_CCR);
   assign wr_tdr   = write_i && (reg_addr == USB_TDR);
   assign wr_sta   = write_i && (reg_addr == USB_STA);

   // byte-enabled merge of CCR and TDR
   always_comb begin
      ccr_nxt = ccr_q;
      tdr_nxt = tdr_q;
      if (wr_ccr && data_be_i[0])
         ccr_nxt = wdata_i[1:0];
      for (int i = 0; i < 4; i++) begin
         if (wr_tdr && data_be_i[i])
            tdr_nxt.raw[8*i +: 8] = wdata_i[8*i +: 8];
      end
   end

   assign clr_recv = wr_sta && data_be_i[0] && wdata_i[STA_RECV_VALID];
   assign rdr_load = ctrl.up_valid && ctrl.rdr_free; // upward transfer

   assign ctrl.mode        = ccr_nxt;       // selector registers it at this edge
   assign ctrl.send_word   = tdr_nxt;
   assign ctrl.send_strobe = wr_tdr && !ctrl.busy;
   assign ctrl.rdr_free    = !recv_valid_q;
   assign ctrl.flush_ovf   = wr_sta && data_be_i[0] && wdata_i[STA_OVERFLOW];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ccr_q        <= MODE_IDLE;
         rdr_q        <= 8'h00;
         recv_valid_q <= 1'b0;
         ovf_q        <= 1'b0;
      end else begin
         ccr_q <= ccr_nxt;
         if (rdr_load) begin
            rdr_q        <= ctrl.up_data;
            recv_valid_q <= 1'b1;
         end else if (clr_recv) begin
            recv_valid_q <= 1'b0;
         end
         if (ctrl.flush_ovf)
            ovf_q <= 1'b0; // a clashing overflow comes back a cycle later
         else if (ctrl.overflow)
            ovf_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      tdr_q <= tdr_nxt;
   end

   always_comb begin
      sta                 = '0;
      sta[STA_CONNECTED]  = ctrl.connected;
      sta[STA_RECV_VALID] = recv_valid_q;
      sta[STA_BUSY]       = ctrl.busy;
      sta[STA_OVERFLOW]   = ovf_q;
   end

   always_comb begin
      case (reg_addr)
         USB_CCR: rdata_o = {30'b0, ccr_q};
         USB_RDR: rdata_o = {24'b0, rdr_q};
         USB_TDR: rdata_o = tdr_q.raw;
         default: rdata_o = {28'b0, sta};
      endcase
   end

endmodule

// ==== usb_serial_fn.sv ====
`timescale 1ns/1ns

module usb_serial_fn #(
   parameter int RX_DEPTH = 4
) (
   input logic  clk_i,
   usb_fn_if.fn bus
);

   localparam int AW = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
   localparam int CW = $clog2(RX_DEPTH + 1);

   logic [7:0]    mem [RX_DEPTH];
   logic [AW-1:0] wr_ptr_q;
   logic [AW-1:0] rd_ptr_q;
   logic [CW-1:0] count_q;
   logic          full;
   logic          push;
   logic          pop;
   logic          tx_valid_q;
   logic [7:0]    tx_data_q;

   function automatic logic [AW-1:0] inc_ptr(input logic [AW-1:0] p);
      return (p == AW'(RX_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   assign full = (count_q == CW'(RX_DEPTH));
   assign pop  = bus.up_take;                       // only ever with up_valid
   assign push = bus.host_rx_valid && (!full || pop); // a pop makes room this edge

   assign bus.overflow = bus.host_rx_valid && full && !pop;

   always_ff @(posedge clk_i) begin
      if (bus.fn_rst) begin
         wr_ptr_q   <= '0;
         rd_ptr_q   <= '0;
         count_q    <= '0;
         tx_valid_q <= 1'b0;
      end else begin
         if (push)
            wr_ptr_q <= inc_ptr(wr_ptr_q);
         if (pop)
            rd_ptr_q <= inc_ptr(rd_ptr_q);
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         tx_valid_q <= bus.send_strobe; // one byte per TDR write
      end
   end

   always_ff @(posedge clk_i) begin
      if (push)
         mem[wr_ptr_q] <= bus.host_rx_data;
      if (bus.send_strobe)
         tx_data_q <= bus.send_word.ser.data_byte;
   end

   assign bus.up_valid      = (count_q != '0);
   assign bus.up_data       = mem[rd_ptr_q];
   assign bus.host_tx_valid = tx_valid_q;
   assign bus.host_tx_data  = tx_data_q;
   assign bus.busy          = 1'b0;

   a_fifo_count: assert property (@(posedge clk_i) disable iff (bus.fn_rst)
      count_q <= CW'(RX_DEPTH));

endmodule
